// File: cp0_params.svh
`ifndef CP0_PARAMS_SVH
`define CP0_PARAMS_SVH

// Joint TLB geometry
// Entry count must be a power of two that fits the index width

`define TLB_ENTRIES 16
`define TLB_IDX_W 4

// Timer reset values
// Compare starts far from Count so no timer interrupt follows reset

`define COUNT_RESET 32'h0000_0000
`define COMPARE_RESET 32'hffff_ffff

// General exception vector offset from the vector base
// Used by the fetch stage when it redirects on an exception

`define EXC_VEC_OFFSET 32'h0000_0180

`endif

// File: cp0_pkg.sv
package cp0_pkg;

    // Register address is rd concatenated with sel
    typedef enum logic [7:0] {
        addr_index    = {5'd0, 3'd0},
        addr_random   = {5'd1, 3'd0},
        addr_entrylo0 = {5'd2, 3'd0},
        addr_entrylo1 = {5'd3, 3'd0},
        addr_context  = {5'd4, 3'd0},
        addr_wired    = {5'd6, 3'd0},
        addr_badvaddr = {5'd8, 3'd0},
        addr_count    = {5'd9, 3'd0},
        addr_entryhi  = {5'd10, 3'd0},
        addr_compare  = {5'd11, 3'd0},
        addr_status   = {5'd12, 3'd0},
        addr_cause    = {5'd13, 3'd0},
        addr_epc      = {5'd14, 3'd0}
    } cp0_addr_e;

    // Exception as flagged by the memory stage
    typedef enum logic [4:0] {
        exc_none,
        exc_int,
        exc_tlbl_refill,
        exc_tlbl_invalid,
        exc_tlbs_refill,
        exc_tlbs_invalid,
        exc_mod,
        exc_adel,
        exc_ades,
        exc_sys,
        exc_bp,
        exc_ri,
        exc_ov
    } exc_type_e;

    typedef enum logic [4:0] {
        code_int  = 5'd0,
        code_mod  = 5'd1,
        code_tlbl = 5'd2,
        code_tlbs = 5'd3,
        code_adel = 5'd4,
        code_ades = 5'd5,
        code_sys  = 5'd8,
        code_bp   = 5'd9,
        code_ri   = 5'd10,
        code_ov   = 5'd12
    } exc_code_e;

endpackage

// File: tlb_pkg.sv
package tlb_pkg;

    typedef enum logic [2:0] {
        op_none  = 3'd0,
        op_tlbr  = 3'd1,
        op_tlbwi = 3'd2,
        op_tlbwr = 3'd3,
        op_tlbp  = 3'd4
    } tlb_op_e;

    // Same bit order as EntryLo bits 25..1
    typedef struct packed {
        logic [19:0] pfn;
        logic [2:0]  c;
        logic        d;
        logic        v;
    } tlb_page_t;

    typedef struct packed {
        logic [18:0]          vpn2;
        logic [7:0]           asid;
        logic                 g;
        tlb_page_t [1:0]      page;   // Index 0 is the even page
    } tlb_entry_t;

endpackage

// File: tlb_if.sv
`timescale 1ns/1ps
`include "cp0_params.svh"

interface tlb_if;
    import tlb_pkg::*;

    tlb_op_e               op;            // Already qualified by the stage
    tlb_entry_t            entry_wr;
    logic [`TLB_IDX_W-1:0] wr_index;      // Random on tlbwr, Index otherwise
    logic [18:0]           probe_vpn2;
    logic [7:0]            probe_asid;    // Also the current ASID for lookups
    tlb_entry_t            entry_rd;
    logic                  probe_found;
    logic [`TLB_IDX_W-1:0] probe_index;

    modport cp0 (
        output op,
        output entry_wr,
        output wr_index,
        output probe_vpn2,
        output probe_asid,
        input  entry_rd,
        input  probe_found,
        input  probe_index
    );

    modport tlb (
        input  op,
        input  entry_wr,
        input  wr_index,
        input  probe_vpn2,
        input  probe_asid,
        output entry_rd,
        output probe_found,
        output probe_index
    );

endinterface

// File: cp0_regs.sv
`timescale 1ns/1ps
`include "cp0_params.svh"

module cp0_regs (
    input  logic               clk,
    input  logic               reset,
    input  logic               valid,
    input  logic               mtc0,
    input  logic               eret,
    input  tlb_pkg::tlb_op_e   tlb_op,
    input  cp0_pkg::exc_type_e exc_type,
    input  logic               bd,
    input  logic [31:0]        pc,
    input  logic [31:0]        alu_result,
    input  cp0_pkg::cp0_addr_e reg_addr,
    input  logic [5:0]         ext_int,
    output logic [31:0]        rdata,
    output logic               eret_flush,
    output logic [31:0]        epc,
    output logic               int_req,
    tlb_if.cp0                 tlb
);
    import cp0_pkg::*;
    import tlb_pkg::*;

    localparam logic [`TLB_IDX_W-1:0] last_idx = `TLB_IDX_W'(`TLB_ENTRIES - 1);

    logic                  ex;
    logic                  ex_tlb;
    logic                  ex_addr;
    logic                  mtc0_we;
    tlb_op_e               tlb_go;
    exc_code_e             exc_code_next;
    logic [31:0]           bad_vaddr_next;

    logic [7:0]            status_im;
    logic                  status_exl;
    logic                  status_ie;

    logic                  cause_bd;
    logic                  cause_ti;
    logic [1:0]            cause_ip_sw;
    exc_code_e             cause_exc_code;
    logic [7:0]            cause_ip;

    logic                  tick;
    logic [31:0]           count;
    logic [31:0]           compare;

    logic                  index_p;
    logic [`TLB_IDX_W-1:0] index_idx;
    logic [`TLB_IDX_W-1:0] random_idx;
    logic [`TLB_IDX_W-1:0] wired;
    logic [18:0]           entryhi_vpn2;
    logic [7:0]            entryhi_asid;
    tlb_page_t             entrylo_page [2];
    logic                  entrylo_g [2];
    logic [8:0]            context_pte_base;
    logic [18:0]           context_bad_vpn2;
    logic [31:0]           bad_vaddr;

    assign ex         = valid && (exc_type != exc_none);
    assign mtc0_we    = valid && mtc0 && (exc_type == exc_none);
    assign eret_flush = valid && eret && (exc_type == exc_none);
    assign tlb_go     = (valid && exc_type == exc_none) ? tlb_op : op_none;

    assign ex_tlb  = ex && (exc_type inside {exc_tlbl_refill, exc_tlbl_invalid,
                                             exc_tlbs_refill, exc_tlbs_invalid, exc_mod});
    assign ex_addr = ex_tlb || (ex && (exc_type inside {exc_adel, exc_ades}));

    always_comb begin
        case (exc_type)
            exc_tlbl_refill, exc_tlbl_invalid: exc_code_next = code_tlbl;
            exc_tlbs_refill, exc_tlbs_invalid: exc_code_next = code_tlbs;
            exc_mod:  exc_code_next = code_mod;
            exc_adel: exc_code_next = code_adel;
            exc_ades: exc_code_next = code_ades;
            exc_sys:  exc_code_next = code_sys;
            exc_bp:   exc_code_next = code_bp;
            exc_ri:   exc_code_next = code_ri;
            exc_ov:   exc_code_next = code_ov;
            default:  exc_code_next = code_int;
        endcase
    end

    // A misaligned pc means the fetch faulted, otherwise the data address did
    always_comb begin
        if (exc_type == exc_adel && pc[1:0] != 2'b00) begin
            bad_vaddr_next = pc;
        end else begin
            bad_vaddr_next = alu_result;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            status_im  <= '0;
            status_exl <= 1'b0;
            status_ie  <= 1'b0;
        end else begin
            if (ex) begin
                status_exl <= 1'b1;
            end else if (eret_flush) begin
                status_exl <= 1'b0;
            end else if (mtc0_we && reg_addr == addr_status) begin
                status_exl <= alu_result[1];
            end
            if (mtc0_we && reg_addr == addr_status) begin
                status_im <= alu_result[15:8];
                status_ie <= alu_result[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cause_bd       <= 1'b0;
            cause_ti       <= 1'b0;
            cause_ip_sw    <= '0;
            cause_exc_code <= code_int;
        end else begin
            if (ex && !status_exl) begin
                cause_bd <= bd;
            end
            if (ex) begin
                cause_exc_code <= exc_code_next;
            end
            if (mtc0_we && reg_addr == addr_cause) begin
                cause_ip_sw <= alu_result[9:8];   // Only the software bits
            end
            if (mtc0_we && reg_addr == addr_compare) begin
                cause_ti <= 1'b0;                 // Writing Compare acknowledges
            end else if (count == compare) begin
                cause_ti <= 1'b1;
            end
        end
    end

    // Timer shares line 5 with the highest external interrupt
    assign cause_ip = {ext_int[5] | cause_ti, ext_int[4:0], cause_ip_sw};
    assign int_req  = status_ie && !status_exl && |(status_im & cause_ip);

    always_ff @(posedge clk) begin
        if (reset) begin
            tick    <= 1'b0;
            count   <= `COUNT_RESET;
            compare <= `COMPARE_RESET;
        end else begin
            tick <= !tick;                        // Count runs at half clock rate
            if (mtc0_we && reg_addr == addr_count) begin
                count <= alu_result;
            end else if (tick) begin
                count <= count + 32'd1;
            end
            if (mtc0_we && reg_addr == addr_compare) begin
                compare <= alu_result;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            random_idx <= last_idx;
            wired      <= '0;
            index_p    <= 1'b0;
            index_idx  <= '0;
        end else begin
            if (mtc0_we && reg_addr == addr_wired) begin
                wired      <= alu_result[`TLB_IDX_W-1:0];
                random_idx <= last_idx;           // Restart above the wired range
            end else if (random_idx == last_idx) begin
                random_idx <= wired;
            end else begin
                random_idx <= random_idx + 1'b1;
            end
            if (mtc0_we && reg_addr == addr_index) begin
                index_idx <= alu_result[`TLB_IDX_W-1:0];
            end else if (tlb_go == op_tlbp) begin
                index_p <= !tlb.probe_found;
                if (tlb.probe_found) begin
                    index_idx <= tlb.probe_index;
                end
            end
        end
    end

    // EntryHi ASID feeds every lookup so it starts known
    always_ff @(posedge clk) begin
        if (reset) begin
            entryhi_vpn2 <= '0;
            entryhi_asid <= '0;
        end else if (ex_tlb) begin
            entryhi_vpn2 <= alu_result[31:13];    // ASID stays for the refill handler
        end else if (mtc0_we && reg_addr == addr_entryhi) begin
            entryhi_vpn2 <= alu_result[31:13];
            entryhi_asid <= alu_result[7:0];
        end else if (tlb_go == op_tlbr) begin
            entryhi_vpn2 <= tlb.entry_rd.vpn2;
            entryhi_asid <= tlb.entry_rd.asid;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (mtc0_we && reg_addr == ((i == 0) ? addr_entrylo0 : addr_entrylo1)) begin
                entrylo_page[i] <= tlb_page_t'(alu_result[25:1]);
                entrylo_g[i]    <= alu_result[0];
            end else if (tlb_go == op_tlbr) begin
                entrylo_page[i] <= tlb.entry_rd.page[i];
                entrylo_g[i]    <= tlb.entry_rd.g;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex_tlb) begin
            context_bad_vpn2 <= alu_result[31:13];
        end
        if (mtc0_we && reg_addr == addr_context) begin
            context_pte_base <= alu_result[31:23];
        end
        if (ex_addr) begin
            bad_vaddr <= bad_vaddr_next;
        end
        if (ex && !status_exl) begin
            epc <= bd ? pc - 32'd4 : pc;          // Point back at the branch
        end else if (mtc0_we && reg_addr == addr_epc) begin
            epc <= alu_result;
        end
    end

    assign tlb.op         = tlb_go;
    assign tlb.wr_index   = (tlb_go == op_tlbwr) ? random_idx : index_idx;
    assign tlb.probe_vpn2 = entryhi_vpn2;
    assign tlb.probe_asid = entryhi_asid;
    assign tlb.entry_wr   = '{vpn2: entryhi_vpn2,
                              asid: entryhi_asid,
                              g:    entrylo_g[0] & entrylo_g[1],
                              page: {entrylo_page[1], entrylo_page[0]}};

    always_comb begin
        case (reg_addr)
            addr_index:    rdata = {index_p, 31'(index_idx)};
            addr_random:   rdata = 32'(random_idx);
            addr_entrylo0: rdata = {6'b0, entrylo_page[0], entrylo_g[0]};
            addr_entrylo1: rdata = {6'b0, entrylo_page[1], entrylo_g[1]};
            addr_context:  rdata = {context_pte_base, context_bad_vpn2, 4'b0};
            addr_wired:    rdata = 32'(wired);
            addr_badvaddr: rdata = bad_vaddr;
            addr_count:    rdata = count;
            addr_entryhi:  rdata = {entryhi_vpn2, 5'b0, entryhi_asid};
            addr_compare:  rdata = compare;
            addr_status:   rdata = {16'b0, status_im, 6'b0, status_exl, status_ie};
            addr_cause:    rdata = {cause_bd, cause_ti, 14'b0, cause_ip, 1'b0,
                                    cause_exc_code, 2'b0};
            addr_epc:      rdata = epc;
            default:       rdata = '0;
        endcase
    end

endmodule

// File: tlb_array.sv
`timescale 1ns/1ps
`include "cp0_params.svh"

module tlb_array (
    input  logic        clk,
    input  logic        reset,
    tlb_if.tlb          tlb,
    input  logic [31:0] lookup_vaddr,
    output logic [31:0] lookup_paddr,
    output logic        lookup_miss,
    output logic        lookup_invalid,
    output logic        lookup_dirty_fault
);
    import tlb_pkg::*;

    tlb_entry_t              entries [`TLB_ENTRIES];
    logic [`TLB_ENTRIES-1:0] probe_hit;
    logic [`TLB_ENTRIES-1:0] lookup_hit;
    tlb_entry_t              lookup_entry;
    tlb_page_t               lookup_page;
    logic                    lookup_found;

    // Global entries ignore the ASID
    function automatic logic entry_match(
        input tlb_entry_t  e,
        input logic [18:0] vpn2,
        input logic [7:0]  asid
    );
        return (e.vpn2 == vpn2) && (e.g || e.asid == asid);
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                entries[i] <= '0;                 // Tags and valid bits cleared
            end
        end else if (tlb.op == op_tlbwi || tlb.op == op_tlbwr) begin
            entries[tlb.wr_index] <= tlb.entry_wr;
        end
    end

    assign tlb.entry_rd = entries[tlb.wr_index];  // Index-selected outside tlbwr

    // Lowest matching entry wins if software left duplicates
    always_comb begin
        tlb.probe_index = '0;
        lookup_entry    = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            probe_hit[i]  = entry_match(entries[i], tlb.probe_vpn2, tlb.probe_asid);
            lookup_hit[i] = entry_match(entries[i], lookup_vaddr[31:13], tlb.probe_asid);
            if (probe_hit[i]) begin
                tlb.probe_index = `TLB_IDX_W'(i);
            end
            if (lookup_hit[i]) begin
                lookup_entry = entries[i];
            end
        end
    end

    assign tlb.probe_found = |probe_hit;

    assign lookup_found = |lookup_hit;
    assign lookup_page  = lookup_entry.page[lookup_vaddr[12]];   // Even or odd 4 KB page
    assign lookup_paddr = {lookup_page.pfn, lookup_vaddr[11:0]};

    assign lookup_miss        = !lookup_found;
    assign lookup_invalid     = lookup_found && !lookup_page.v;
    // Stage qualifies this with a store
    assign lookup_dirty_fault = lookup_found && lookup_page.v && !lookup_page.d;

endmodule

// File: cp0_top.sv
`timescale 1ns/1ps

module cp0_top (
    input  logic               clk,
    input  logic               reset,

    input  logic               valid,
    input  logic               mtc0,
    input  logic               eret,
    input  tlb_pkg::tlb_op_e   tlb_op,
    input  cp0_pkg::exc_type_e exc_type,
    input  logic               bd,
    input  logic [31:0]        pc,
    input  logic [31:0]        alu_result,
    input  cp0_pkg::cp0_addr_e reg_addr,
    input  logic [5:0]         ext_int,

    output logic [31:0]        rdata,
    output logic               eret_flush,
    output logic [31:0]        epc,
    output logic               int_req,

    input  logic [31:0]        lookup_vaddr,
    output logic [31:0]        lookup_paddr,
    output logic               lookup_miss,
    output logic               lookup_invalid,
    output logic               lookup_dirty_fault
);

    tlb_if tlb_bus ();

    cp0_regs cp0_regs_i (
        .clk        (clk),
        .reset      (reset),
        .valid      (valid),
        .mtc0       (mtc0),
        .eret       (eret),
        .tlb_op     (tlb_op),
        .exc_type   (exc_type),
        .bd         (bd),
        .pc         (pc),
        .alu_result (alu_result),
        .reg_addr   (reg_addr),
        .ext_int    (ext_int),
        .rdata      (rdata),
        .eret_flush (eret_flush),
        .epc        (epc),
        .int_req    (int_req),
        .tlb        (tlb_bus.cp0)
    );

    tlb_array tlb_array_i (
        .clk                (clk),
        .reset              (reset),
        .tlb                (tlb_bus.tlb),
        .lookup_vaddr       (lookup_vaddr),
        .lookup_paddr       (lookup_paddr),
        .lookup_miss        (lookup_miss),
        .lookup_invalid     (lookup_invalid),
        .lookup_dirty_fault (lookup_dirty_fault)
    );

endmodule

// File: cp0_top_tb.sv
`timescale 1ns/1ps
`include "cp0_params.svh"

module cp0_top_tb;
    import cp0_pkg::*;
    import tlb_pkg::*;

    localparam int          cycle_limit = 4000;   // Well above what all tests need
    localparam logic [31:0] idx_mask    = 32'((1 << `TLB_IDX_W) - 1);
    localparam logic [31:0] last_idx    = 32'(`TLB_ENTRIES - 1);

    logic        clk;
    logic        reset;
    logic        valid, mtc0, eret, bd;
    tlb_op_e     tlb_op;
    exc_type_e   exc_type;
    logic [31:0] pc, alu_result;
    cp0_addr_e   reg_addr;
    logic [5:0]  ext_int;
    logic [31:0] rdata, epc;
    logic        eret_flush, int_req;
    logic [31:0] lookup_vaddr, lookup_paddr;
    logic        lookup_miss, lookup_invalid, lookup_dirty_fault;

    logic [31:0] lfsr_state;
    int          cycle_count;
    int          err_count;
    int          tests_run;
    int          tests_failed;

    // Outputs captured mid-cycle
    logic [31:0] seen_rdata, seen_paddr, seen_epc;
    logic        seen_flush, seen_int_req, seen_miss, seen_invalid, seen_dirty;

    // Entry from the TLB test reused for translation
    logic [31:0]           tlb_hi, tlb_lo0, tlb_lo1;
    logic [`TLB_IDX_W-1:0] tlb_idx;

    cp0_top cp0_top_i (.*);

    always #10 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input int nbits);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic logic [31:0] writable_mask(input cp0_addr_e addr);
        case (addr)
            addr_status:                  return 32'h0000_ff03;   // IM, EXL, IE
            addr_cause:                   return 32'h0000_0300;   // Software IP only
            addr_entryhi:                 return 32'hffff_e0ff;
            addr_entrylo0, addr_entrylo1: return 32'h03ff_ffff;
            addr_index, addr_wired:       return idx_mask;
            addr_context:                 return 32'hff80_0000;   // PTEBase
            default:                      return 32'hffff_ffff;
        endcase
    endfunction

    task automatic finish_cycle();
        @(posedge clk);
        #2;
        valid      = 1'b0;
        mtc0       = 1'b0;
        eret       = 1'b0;
        tlb_op     = op_none;
        exc_type   = exc_none;
        bd         = 1'b0;
        pc         = '0;
        alu_result = '0;
    endtask

    task automatic run_cycle();
        #10;
        seen_rdata   = rdata;
        seen_epc     = epc;
        seen_flush   = eret_flush;
        seen_int_req = int_req;
        seen_paddr   = lookup_paddr;
        seen_miss    = lookup_miss;
        seen_invalid = lookup_invalid;
        seen_dirty   = lookup_dirty_fault;
        finish_cycle();
    endtask

    task automatic write_reg(input cp0_addr_e addr, input logic [31:0] data);
        valid      = 1'b1;
        mtc0       = 1'b1;
        reg_addr   = addr;
        alu_result = data;
        run_cycle();
    endtask

    task automatic read_reg(input cp0_addr_e addr);
        reg_addr = addr;
        run_cycle();
    endtask

    task automatic tlb_command(input tlb_op_e op);
        valid  = 1'b1;
        tlb_op = op;
        run_cycle();
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("** Error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
        err_count++;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (err_count != errors_before) begin
            tests_failed++;
            $display("%-22s failed with %0d errors", name, err_count - errors_before);
        end else begin
            $display("%-22s passed", name);
        end
    endtask

    task automatic register_rw();
        cp0_addr_e   regs [10];
        string       names [10];
        logic [31:0] data;
        logic [31:0] actual;
        int          errors_before;
        errors_before = err_count;
        regs  = '{addr_status, addr_cause, addr_epc, addr_entryhi, addr_entrylo0,
                  addr_entrylo1, addr_index, addr_wired, addr_context, addr_compare};
        names = '{"Status", "Cause", "EPC", "EntryHi", "EntryLo0",
                  "EntryLo1", "Index", "Wired", "Context", "Compare"};
        read_reg(addr_compare);
        if (seen_rdata !== `COMPARE_RESET)
            report_mismatch("Compare", `COMPARE_RESET, seen_rdata);
        for (int i = 0; i < 10; i++) begin
            data = lfsr_next(32);
            write_reg(regs[i], data);
            read_reg(regs[i]);
            actual = seen_rdata;
            if (regs[i] == addr_context)
                actual = actual & writable_mask(addr_context);   // BadVPN2 not set yet
            if (actual !== (data & writable_mask(regs[i])))
                report_mismatch(names[i], data & writable_mask(regs[i]), actual);
        end
        // Compare was written last, so data is its value
        exc_type = exc_sys;
        write_reg(addr_compare, ~data);
        read_reg(addr_compare);
        if (seen_rdata !== data)
            report_mismatch("Compare", data, seen_rdata);
        write_reg(addr_status, 32'h0);
        finish_test("register_rw", errors_before);
    endtask

    task automatic exception_eret();
        logic [31:0] fault_pc;
        int          errors_before;
        errors_before = err_count;
        fault_pc   = {lfsr_next(30), 2'b10};           // Misaligned fetch
        valid      = 1'b1;
        exc_type   = exc_adel;
        bd         = 1'b1;
        pc         = fault_pc;
        alu_result = lfsr_next(32);
        run_cycle();
        read_reg(addr_epc);
        if (seen_rdata !== fault_pc - 32'd4)
            report_mismatch("EPC", fault_pc - 32'd4, seen_rdata);
        if (seen_epc !== fault_pc - 32'd4)
            report_mismatch("epc", fault_pc - 32'd4, seen_epc);
        read_reg(addr_cause);
        if (seen_rdata[31] !== 1'b1)
            report_mismatch("Cause.BD", 1'b1, seen_rdata[31]);
        if (seen_rdata[6:2] !== code_adel)
            report_mismatch("Cause.ExcCode", code_adel, seen_rdata[6:2]);
        read_reg(addr_badvaddr);
        if (seen_rdata !== fault_pc)
            report_mismatch("BadVAddr", fault_pc, seen_rdata);
        read_reg(addr_status);
        if (seen_rdata[1] !== 1'b1)
            report_mismatch("Status.EXL", 1'b1, seen_rdata[1]);
        valid    = 1'b1;
        exc_type = exc_ov;
        pc       = {lfsr_next(30), 2'b00};
        run_cycle();
        read_reg(addr_epc);
        if (seen_rdata !== fault_pc - 32'd4)
            report_mismatch("EPC", fault_pc - 32'd4, seen_rdata);
        if (seen_epc !== fault_pc - 32'd4)
            report_mismatch("epc", fault_pc - 32'd4, seen_epc);
        valid = 1'b1;
        eret  = 1'b1;
        run_cycle();
        if (seen_flush !== 1'b1)
            report_mismatch("eret_flush", 1'b1, seen_flush);
        read_reg(addr_status);
        if (seen_rdata[1] !== 1'b0)
            report_mismatch("Status.EXL", 1'b0, seen_rdata[1]);
        finish_test("exception_eret", errors_before);
    endtask

    task automatic timer_interrupts();
        logic [31:0] count_now;
        logic        ti_seen;
        int          polls;
        int          errors_before;
        errors_before = err_count;
        write_reg(addr_status, 32'h0);
        write_reg(addr_cause, 32'h0);
        read_reg(addr_count);
        count_now = seen_rdata;
        write_reg(addr_compare, count_now + 32'd20);
        ti_seen = 1'b0;
        polls   = 0;
        while (!ti_seen && polls < 45) begin
            read_reg(addr_cause);
            ti_seen = seen_rdata[30];
            polls++;
        end
        if (!ti_seen) begin
            $display("Error at time %0t: timer interrupt did not appear in 45 cycles", $time);
            err_count++;
        end
        write_reg(addr_status, 32'h0000_8001);      // IE with IM7
        read_reg(addr_status);
        if (seen_int_req !== 1'b1)
            report_mismatch("int_req", 1'b1, seen_int_req);
        write_reg(addr_compare, count_now + 32'h0010_0000);
        read_reg(addr_cause);
        if (seen_rdata[30] !== 1'b0)
            report_mismatch("Cause.TI", 1'b0, seen_rdata[30]);
        if (seen_int_req !== 1'b0)
            report_mismatch("int_req", 1'b0, seen_int_req);
        write_reg(addr_status, 32'h0000_0101);      // IE with IM0
        write_reg(addr_cause, 32'h0000_0100);       // Software interrupt 0
        read_reg(addr_cause);
        if (seen_int_req !== 1'b1)
            report_mismatch("int_req", 1'b1, seen_int_req);
        write_reg(addr_status, 32'h0000_0103);
        read_reg(addr_status);
        if (seen_int_req !== 1'b0)
            report_mismatch("int_req", 1'b0, seen_int_req);
        write_reg(addr_cause, 32'h0);
        write_reg(addr_status, 32'h0);
        finish_test("timer_interrupts", errors_before);
    endtask

    task automatic tlb_write_read_probe();
        logic [18:0] vpn2;
        logic [6:0]  asid;
        logic [19:0] pfn;
        logic [2:0]  attr;
        int          errors_before;
        errors_before = err_count;
        vpn2    = 19'(lfsr_next(19));
        asid    = 7'(lfsr_next(7));
        tlb_hi  = {vpn2, 5'b0, asid, 1'b1};         // Odd ASID never hits a cleared entry
        pfn     = 20'(lfsr_next(20));
        attr    = 3'(lfsr_next(3));
        tlb_lo0 = {6'b0, pfn, attr, 1'b1, 1'b1, 1'b0};
        pfn     = 20'(lfsr_next(20));
        attr    = 3'(lfsr_next(3));
        tlb_lo1 = {6'b0, pfn, attr, 1'b0, 1'b1, 1'b0};
        tlb_idx = `TLB_IDX_W'(lfsr_next(`TLB_IDX_W));
        write_reg(addr_entryhi, tlb_hi);
        write_reg(addr_entrylo0, tlb_lo0);
        write_reg(addr_entrylo1, tlb_lo1);
        write_reg(addr_index, 32'(tlb_idx));
        tlb_command(op_tlbwi);
        write_reg(addr_entryhi, lfsr_next(32));
        write_reg(addr_entrylo0, lfsr_next(32));
        write_reg(addr_entrylo1, lfsr_next(32));
        tlb_command(op_tlbr);
        read_reg(addr_entryhi);
        if (seen_rdata !== tlb_hi)
            report_mismatch("EntryHi", tlb_hi, seen_rdata);
        read_reg(addr_entrylo0);
        if (seen_rdata !== tlb_lo0)
            report_mismatch("EntryLo0", tlb_lo0, seen_rdata);
        read_reg(addr_entrylo1);
        if (seen_rdata !== tlb_lo1)
            report_mismatch("EntryLo1", tlb_lo1, seen_rdata);
        write_reg(addr_index, 32'(tlb_idx) ^ 32'd1);
        tlb_command(op_tlbp);
        read_reg(addr_index);
        if (seen_rdata !== 32'(tlb_idx))
            report_mismatch("Index", 32'(tlb_idx), seen_rdata);
        write_reg(addr_entryhi, tlb_hi ^ 32'h0000_2000);   // Lowest VPN2 bit flipped
        tlb_command(op_tlbp);
        read_reg(addr_index);
        if (seen_rdata[31] !== 1'b1)
            report_mismatch("Index.P", 1'b1, seen_rdata[31]);
        finish_test("tlb_write_read_probe", errors_before);
    endtask

    task automatic address_translation();
        logic [11:0] offset;
        int          errors_before;
        errors_before = err_count;
        offset = 12'(lfsr_next(12));
        write_reg(addr_entryhi, tlb_hi);
        lookup_vaddr = {tlb_hi[31:13], 1'b0, offset};
        run_cycle();
        if (seen_miss !== 1'b0)
            report_mismatch("lookup_miss", 1'b0, seen_miss);
        if (seen_paddr !== {tlb_lo0[25:6], offset})
            report_mismatch("lookup_paddr", {tlb_lo0[25:6], offset}, seen_paddr);
        if (seen_dirty !== 1'b0)
            report_mismatch("lookup_dirty_fault", 1'b0, seen_dirty);
        lookup_vaddr = {tlb_hi[31:13], 1'b1, offset};
        run_cycle();
        if (seen_paddr !== {tlb_lo1[25:6], offset})
            report_mismatch("lookup_paddr", {tlb_lo1[25:6], offset}, seen_paddr);
        if (seen_dirty !== 1'b1)                          // Odd page has D clear
            report_mismatch("lookup_dirty_fault", 1'b1, seen_dirty);
        lookup_vaddr = {tlb_hi[31:13] ^ 19'h1, 1'b0, offset};
        run_cycle();
        if (seen_miss !== 1'b1)
            report_mismatch("lookup_miss", 1'b1, seen_miss);
        write_reg(addr_entrylo0, tlb_lo0 & ~32'h2);       // Even page loses V
        write_reg(addr_entrylo1, tlb_lo1);
        write_reg(addr_index, 32'(tlb_idx));
        tlb_command(op_tlbwi);
        lookup_vaddr = {tlb_hi[31:13], 1'b0, offset};
        run_cycle();
        if (seen_invalid !== 1'b1)
            report_mismatch("lookup_invalid", 1'b1, seen_invalid);
        if (seen_miss !== 1'b0)
            report_mismatch("lookup_miss", 1'b0, seen_miss);
        write_reg(addr_entryhi, tlb_hi ^ 32'h0000_0080);
        run_cycle();
        if (seen_miss !== 1'b1)
            report_mismatch("lookup_miss", 1'b1, seen_miss);
        finish_test("address_translation", errors_before);
    endtask

    task automatic random_wired();
        logic [31:0] rnd;
        logic [18:0] vpn2;
        int          errors_before;
        errors_before = err_count;
        write_reg(addr_wired, 32'd5);
        for (int i = 0; i < 40; i++) begin
            read_reg(addr_random);
            if (seen_rdata < 32'd5 || seen_rdata > last_idx) begin
                $display("** Error at time %0t: Random expected 5..%0d, got %0d",
                         $time, last_idx, seen_rdata);
                err_count++;
            end
        end
        vpn2 = tlb_hi[31:13] ^ {18'(lfsr_next(18)), 1'b1};   // Never the earlier VPN2
        write_reg(addr_entryhi, {vpn2, 5'b0, tlb_hi[7:0]});
        reg_addr = addr_random;
        tlb_command(op_tlbwr);
        rnd = seen_rdata;
        tlb_command(op_tlbp);
        read_reg(addr_index);
        if (seen_rdata !== rnd)
            report_mismatch("Index", rnd, seen_rdata);
        finish_test("random_wired", errors_before);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run stopped after %0d cycles without finishing the tests", cycle_limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        valid        = 1'b0;
        mtc0         = 1'b0;
        eret         = 1'b0;
        bd           = 1'b0;
        tlb_op       = op_none;
        exc_type     = exc_none;
        pc           = '0;
        alu_result   = '0;
        reg_addr     = addr_status;
        ext_int      = '0;
        lookup_vaddr = '0;
        lfsr_state   = 32'h5d9c;
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        register_rw();
        exception_eret();
        timer_interrupts();
        tlb_write_read_probe();
        address_translation();
        random_wired();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+.
cp0_pkg.sv
tlb_pkg.sv
tlb_if.sv
cp0_regs.sv
tlb_array.sv
cp0_top.sv
cp0_top_tb.sv

// File: Bender.yml
package:
  name: cp0

export_include_dirs:
  - .

sources:
  - cp0_pkg.sv
  - tlb_pkg.sv
  - tlb_if.sv
  - cp0_regs.sv
  - tlb_array.sv
  - cp0_top.sv
  - target: test
    files:
      - cp0_top_tb.sv
